// File: bench/exec_vectors.txt
// columns: instr rs_val rt_val result dest kind
// kind: 0 none, 1 reg write, 2 mem addr, 3 trap
// r-type rs=8 rt=9 rd=10, immediates rs=8 rt=9
01095020 00000005 00000007 0000000c 0a 1 // add
01095021 7fffffff 00000001 80000000 0a 1 // addu wraps
01095020 7fffffff 00000001 00000000 00 3 // add overflow
01095022 00000010 00000003 0000000d 0a 1 // sub
01095022 80000000 00000001 00000000 00 3 // sub overflow
01095023 80000000 00000001 7fffffff 0a 1 // subu wraps
0109502a ffffffff 00000001 00000001 0a 1 // slt mixed sign
0109502b ffffffff 00000001 00000000 0a 1 // sltu same operands
01095024 f0f0ff00 0ff0f0f0 00f0f000 0a 1 // and
01095025 f0f0ff00 0ff0f0f0 fff0fff0 0a 1 // or
01095026 f0f0ff00 0ff0f0f0 ff000ff0 0a 1 // xor
01095027 f0f0ff00 0ff0f0f0 000f000f 0a 1 // nor
00095100 00000000 12345678 23456780 0a 1 // sll 4
00095202 00000000 87654321 00876543 0a 1 // srl 8
00095203 00000000 87654321 ff876543 0a 1 // sra 8
01095004 00000024 0000000f 000000f0 0a 1 // sllv, only low 5 bits of rs
01095006 00000010 abcd1234 0000abcd 0a 1 // srlv 16
01095007 0000001c 80000000 fffffff8 0a 1 // srav 28
2109fffc 00000010 00000000 0000000c 09 1 // addi -4
21090001 7fffffff 00000000 00000000 00 3 // addi overflow
25090001 7fffffff 00000000 80000000 09 1 // addiu wraps
2509ff00 00001000 00000000 00000f00 09 1 // addiu negative
2909ffff fffffffe 00000000 00000001 09 1 // slti -2 < -1
2909ffff 00000003 00000000 00000000 09 1 // slti 3 < -1
2d09ffff 00000003 00000000 00000001 09 1 // sltiu 3 < ffffffff
3109ff0f ffffffff 00000000 0000ff0f 09 1 // andi zero-extends
35098001 12340000 00000000 12348001 09 1 // ori zero-extends
3909ffff ffff0000 00000000 ffffffff 09 1 // xori zero-extends
3c09beef 00000000 00000000 beef0000 09 1 // lui
8d09fff8 10000020 00000000 10000018 09 2 // lw offset -8
ad090010 10000000 deadbeef 10000010 09 2 // sw offset 16
11090004 00000005 00000005 00000000 00 0 // beq
1509fffc 00000005 00000006 00000000 00 0 // bne
08100000 00000000 00000000 00000000 00 0 // j
0c100000 00000000 00000000 00000000 00 0 // jal
fd090123 00000001 00000002 00000000 00 0 // unknown opcode
01090020 00000001 00000002 00000000 00 0 // add into r0
21000005 00000001 00000000 00000000 00 0 // addi into r0
05010008 00000001 00000000 00000000 00 0 // bgez
0109503f 00000001 00000002 00000000 00 0 // unknown funct

// File: bench/mips_exec_unit_tb.sv
`timescale 1ns/1ps

module mips_exec_unit_tb import mips_exec_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_VEC = 40;
    // six words per vector line in file order
    localparam int VEC_WORDS = 6;
    // longest wait for an ack edge
    localparam int ACK_LIMIT = 8;
    // 20 cycles per vector plus reset and some margin
    localparam int WATCHDOG_CYCLES = NUM_VEC * 20 + 3 + 5;

    logic        clk;
    logic        arst_n;
    logic        req;
    exec_req_t   req_data;
    logic        ack;
    exec_out_t   rsp;

    // flat copy of the vector file
    logic [31:0] vec_mem [0:NUM_VEC*VEC_WORDS-1];
    logic [31:0] lfsr;
    int          v;

    mips_exec_unit mips_exec_unit_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .rsp      (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hung handshake guard
    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("handshake hung, watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog timeout");
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] val);
        int i;
        val = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] time=%0t signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // all three response fields
    task automatic check_rsp(input exec_out_t exp);
        check_value("rsp.result", exp.result, rsp.result);
        check_value("rsp.dest", 32'(exp.dest), 32'(rsp.dest));
        check_value("rsp.kind", 32'(exp.kind), 32'(rsp.kind));
    endtask

    // counts falling edges until ack reaches level
    task automatic wait_ack_level(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
        end while ((ack !== level) && (cycles < ACK_LIMIT));
        if (ack !== level) begin
            $display("ack did not go to %0b within %0d cycles", level, ACK_LIMIT);
            $display("TB FAILED");
            $fatal(1, "handshake timeout");
        end
    endtask

    // one full four-phase transfer starting on a falling edge with ack low
    task automatic run_vector(input int idx);
        exec_req_t   stim;
        exec_out_t   exp;
        logic [31:0] rnd;
        logic [31:0] hold_n;
        logic [31:0] idle_n;
        int          cycles;
        int          base;
        base = idx * VEC_WORDS;
        stim.instr  = vec_mem[base];
        stim.rs_val = vec_mem[base + 1];
        stim.rt_val = vec_mem[base + 2];
        exp.result  = vec_mem[base + 3];
        exp.dest    = vec_mem[base + 4][4:0];
        exp.kind    = result_kind_t'(vec_mem[base + 5][1:0]);
        check_value("ack", 32'd0, 32'(ack));
        req_data = stim;
        req = 1'b1;
        // ack up one edge after req seen
        wait_ack_level(1'b1, cycles);
        check_value("ack rise latency", 32'd1, cycles);
        check_rsp(exp);
        // rsp must not move while req_data is scrambled under a held req
        draw_bits(2, hold_n);
        repeat (hold_n) begin
            draw_bits(32, rnd);
            req_data.instr = rnd;
            draw_bits(32, rnd);
            req_data.rs_val = rnd;
            draw_bits(32, rnd);
            req_data.rt_val = rnd;
            @(negedge clk);
            check_value("ack", 32'd1, 32'(ack));
            check_rsp(exp);
        end
        req = 1'b0;
        // ack down one edge after req low
        wait_ack_level(1'b0, cycles);
        check_value("ack fall latency", 32'd1, cycles);
        check_rsp(exp);
        draw_bits(2, idle_n);
        repeat (idle_n) begin
            @(negedge clk);
            check_value("ack", 32'd0, 32'(ack));
        end
    endtask

    initial begin
        arst_n   = 1'b0;
        req      = 1'b0;
        req_data = '0;
        lfsr     = 32'hef83;
        $readmemh("bench/exec_vectors.txt", vec_mem);
        // reset for 3 cycles
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("ack", 32'd0, 32'(ack));
        arst_n = 1'b1;
        // idle state after reset holds across a clock edge with req low
        @(negedge clk);
        check_value("ack", 32'd0, 32'(ack));
        check_rsp('0);
        for (v = 0; v < NUM_VEC; v++) begin
            run_vector(v);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: logic/alu_control_decode.sv
`timescale 1ns/1ps

module alu_control_decode import mips_exec_pkg::*; (
    input  opcode_t   op,
    input  funct_t    funct,
    output alu_ctrl_t alu_ctrl
);

    always_comb begin
        // unknown opcodes fall back to and
        alu_ctrl = ALU_AND;
        case (op)
            OP_RTYPE: begin
                // function field picks the operation
                case (funct)
                    // signed and unsigned forms share a code
                    FN_ADD, FN_ADDU: begin
                        alu_ctrl = ALU_ADD;
                    end
                    FN_SUB, FN_SUBU: begin
                        alu_ctrl = ALU_SUB;
                    end
                    // compares
                    FN_SLT:  alu_ctrl = ALU_SLT;
                    FN_SLTU: alu_ctrl = ALU_SLTU;
                    // bitwise logic
                    FN_AND:  alu_ctrl = ALU_AND;
                    FN_OR:   alu_ctrl = ALU_OR;
                    FN_XOR:  alu_ctrl = ALU_XOR;
                    FN_NOR:  alu_ctrl = ALU_NOR;
                    // fixed shifts, amount in the instruction
                    FN_SLL:  alu_ctrl = ALU_SLL;
                    FN_SRL:  alu_ctrl = ALU_SRL;
                    FN_SRA:  alu_ctrl = ALU_SRA;
                    // variable shifts, amount from rs
                    FN_SLLV: alu_ctrl = ALU_SLLV;
                    FN_SRLV: alu_ctrl = ALU_SRLV;
                    FN_SRAV: alu_ctrl = ALU_SRAV;
                    // unknown function
                    default: alu_ctrl = ALU_AND;
                endcase
            end
            // address generation base plus offset
            OP_LW, OP_SW: begin
                alu_ctrl = ALU_ADD;
            end
            // control transfer, alu result goes unused
            OP_J, OP_JAL: begin
                alu_ctrl = ALU_ADD;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM: begin
                alu_ctrl = ALU_ADD;
            end
            // immediate arithmetic
            OP_ADDI, OP_ADDIU: begin
                alu_ctrl = ALU_ADD;
            end
            // immediate compares
            OP_SLTI:  alu_ctrl = ALU_SLT;
            OP_SLTIU: alu_ctrl = ALU_SLTU;
            // immediate logic
            OP_ANDI:  alu_ctrl = ALU_AND;
            OP_ORI:   alu_ctrl = ALU_OR;
            OP_XORI:  alu_ctrl = ALU_XOR;
            // lui gets its own code
            OP_LUI:   alu_ctrl = ALU_LUI;
            default:  alu_ctrl = ALU_AND;
        endcase
    end

endmodule

// File: logic/alu_execute.sv
`timescale 1ns/1ps

module alu_execute import mips_exec_pkg::*; (
    input  decoded_t  dec,
    output exec_out_t out
);

    word_t a;
    word_t b;
    word_t sum;
    word_t diff;
    word_t alu_res;
    logic  add_ovf;
    logic  sub_ovf;
    logic  ovf;

    assign a    = dec.op_a;
    assign b    = dec.op_b;
    assign sum  = a + b;
    assign diff = a - b;

    // signed overflow
    // add: equal operand signs, result sign flips
    assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
    // sub: differing operand signs, result takes sign of b
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    // only add and sub can overflow
    assign ovf = ((dec.alu_ctrl == ALU_ADD) && add_ovf) ||
                 ((dec.alu_ctrl == ALU_SUB) && sub_ovf);

    always_comb begin
        case (dec.alu_ctrl)
            ALU_ADD:  alu_res = sum;
            ALU_SUB:  alu_res = diff;
            // signed compare
            ALU_SLT:  alu_res = {31'b0, $signed(a) < $signed(b)};
            // unsigned compare
            ALU_SLTU: alu_res = {31'b0, a < b};
            ALU_AND:  alu_res = a & b;
            ALU_OR:   alu_res = a | b;
            ALU_XOR:  alu_res = a ^ b;
            ALU_NOR:  alu_res = ~(a | b);
            // shifts act on rt, amount already resolved by decode
            ALU_SLL, ALU_SLLV: begin
                alu_res = b << dec.shamt;
            end
            ALU_SRL, ALU_SRLV: begin
                alu_res = b >> dec.shamt;
            end
            // arithmetic right, sign fills in
            ALU_SRA, ALU_SRAV: begin
                alu_res = word_t'($signed(b) >>> dec.shamt);
            end
            // low half of the immediate moves up
            ALU_LUI:  alu_res = {b[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    // outcome resolution
    always_comb begin
        out.result = alu_res;
        out.dest   = dec.dest;
        out.kind   = dec.kind;
        if (dec.ovf_trap && ovf) begin
            // trapped ops write nothing
            out.result = '0;
            out.dest   = '0;
            out.kind   = KIND_TRAP;
        end else if ((dec.kind == KIND_REG_WRITE) && (dec.dest == '0)) begin
            // r0 stays zero, so no write
            out.result = '0;
            out.dest   = '0;
            out.kind   = KIND_NONE;
        end else if (dec.kind == KIND_NONE) begin
            // nothing to report
            out.result = '0;
            out.dest   = '0;
        end
    end

endmodule

// File: logic/instr_decode.sv
`timescale 1ns/1ps

module instr_decode import mips_exec_pkg::*; (
    input  exec_req_t req_data,
    output decoded_t  dec
);

    // instruction fields
    opcode_t     op;
    reg_addr_t   rt;
    reg_addr_t   rd;
    shamt_t      shamt_f;
    funct_t      funct;
    logic [15:0] imm;
    // extended immediates
    word_t       imm_sext;
    word_t       imm_zext;
    alu_ctrl_t   alu_ctrl;

    assign op       = req_data.instr[31:26];
    assign rt       = req_data.instr[20:16];
    assign rd       = req_data.instr[15:11];
    assign shamt_f  = req_data.instr[10:6];
    assign funct    = req_data.instr[5:0];
    assign imm      = req_data.instr[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};
    assign imm_zext = {16'h0000, imm};

    alu_control_decode alu_control_decode_i (
        .op       (op),
        .funct    (funct),
        .alu_ctrl (alu_ctrl)
    );

    always_comb begin
        // r-type defaults
        dec.alu_ctrl = alu_ctrl;
        dec.op_a     = req_data.rs_val;
        dec.op_b     = req_data.rt_val;
        dec.shamt    = shamt_f;
        dec.dest     = rd;
        dec.kind     = KIND_NONE;
        dec.ovf_trap = 1'b0;
        case (op)
            OP_RTYPE: begin
                case (funct)
                    // only signed add and sub trap
                    FN_ADD, FN_SUB: begin
                        dec.kind     = KIND_REG_WRITE;
                        dec.ovf_trap = 1'b1;
                    end
                    FN_ADDU, FN_SUBU, FN_SLT, FN_SLTU,
                    FN_AND, FN_OR, FN_XOR, FN_NOR,
                    FN_SLL, FN_SRL, FN_SRA: begin
                        dec.kind = KIND_REG_WRITE;
                    end
                    // shift amount from low bits of rs
                    FN_SLLV, FN_SRLV, FN_SRAV: begin
                        dec.kind  = KIND_REG_WRITE;
                        dec.shamt = req_data.rs_val[4:0];
                    end
                    default: dec.kind = KIND_NONE;
                endcase
            end
            OP_ADDI: begin
                dec.op_b     = imm_sext;
                dec.dest     = rt;
                dec.kind     = KIND_REG_WRITE;
                dec.ovf_trap = 1'b1;
            end
            // sign-extended immediate forms
            OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                dec.op_b = imm_sext;
                dec.dest = rt;
                dec.kind = KIND_REG_WRITE;
            end
            // zero-extended logic forms, lui too
            OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                dec.op_b = imm_zext;
                dec.dest = rt;
                dec.kind = KIND_REG_WRITE;
            end
            // rt names the load target or the store source
            OP_LW, OP_SW: begin
                dec.op_b = imm_sext;
                dec.dest = rt;
                dec.kind = KIND_MEM_ADDR;
            end
            // branches, jumps, unknown: no result
            default: dec.kind = KIND_NONE;
        endcase
    end

endmodule

// File: logic/mips_exec_pkg.sv
package mips_exec_pkg;

    // field and word widths of the MIPS32 encoding
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [4:0]  alu_ctrl_t;

    // alu control codes
    localparam alu_ctrl_t ALU_ADD  = 5'd0;
    localparam alu_ctrl_t ALU_SUB  = 5'd1;
    localparam alu_ctrl_t ALU_SLT  = 5'd2;
    localparam alu_ctrl_t ALU_SLTU = 5'd3;
    localparam alu_ctrl_t ALU_AND  = 5'd4;
    localparam alu_ctrl_t ALU_OR   = 5'd5;
    localparam alu_ctrl_t ALU_XOR  = 5'd6;
    localparam alu_ctrl_t ALU_NOR  = 5'd7;
    localparam alu_ctrl_t ALU_SLL  = 5'd8;
    localparam alu_ctrl_t ALU_SRL  = 5'd9;
    localparam alu_ctrl_t ALU_SRA  = 5'd10;
    localparam alu_ctrl_t ALU_SLLV = 5'd11;
    localparam alu_ctrl_t ALU_SRLV = 5'd12;
    localparam alu_ctrl_t ALU_SRAV = 5'd13;
    // immediate into the upper half
    localparam alu_ctrl_t ALU_LUI  = 5'd14;

    // primary opcodes
    localparam opcode_t OP_RTYPE  = 6'h00;
    // bltz / bgez family
    localparam opcode_t OP_REGIMM = 6'h01;
    localparam opcode_t OP_J      = 6'h02;
    localparam opcode_t OP_JAL    = 6'h03;
    localparam opcode_t OP_BEQ    = 6'h04;
    localparam opcode_t OP_BNE    = 6'h05;
    localparam opcode_t OP_BLEZ   = 6'h06;
    localparam opcode_t OP_BGTZ   = 6'h07;
    localparam opcode_t OP_ADDI   = 6'h08;
    localparam opcode_t OP_ADDIU  = 6'h09;
    localparam opcode_t OP_SLTI   = 6'h0a;
    localparam opcode_t OP_SLTIU  = 6'h0b;
    localparam opcode_t OP_ANDI   = 6'h0c;
    localparam opcode_t OP_ORI    = 6'h0d;
    localparam opcode_t OP_XORI   = 6'h0e;
    localparam opcode_t OP_LUI    = 6'h0f;
    localparam opcode_t OP_LW     = 6'h23;
    localparam opcode_t OP_SW     = 6'h2b;

    // r-type function codes
    localparam funct_t FN_SLL  = 6'h00;
    localparam funct_t FN_SRL  = 6'h02;
    localparam funct_t FN_SRA  = 6'h03;
    localparam funct_t FN_SLLV = 6'h04;
    localparam funct_t FN_SRLV = 6'h06;
    localparam funct_t FN_SRAV = 6'h07;
    localparam funct_t FN_ADD  = 6'h20;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUB  = 6'h22;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_NOR  = 6'h27;
    localparam funct_t FN_SLT  = 6'h2a;
    localparam funct_t FN_SLTU = 6'h2b;

    // meaning of a reported result, none is zero so an idle rsp is all zero
    typedef enum logic [1:0] {
        KIND_NONE      = 2'd0,
        KIND_REG_WRITE = 2'd1,
        KIND_MEM_ADDR  = 2'd2,
        KIND_TRAP      = 2'd3
    } result_kind_t;

    // request: instruction plus the two register reads
    typedef struct packed {
        word_t instr;
        word_t rs_val;
        word_t rt_val;
    } exec_req_t;

    // decoder output, everything the alu needs
    typedef struct packed {
        alu_ctrl_t    alu_ctrl;
        word_t        op_a;
        word_t        op_b;
        shamt_t       shamt;
        reg_addr_t    dest;
        result_kind_t kind;
        logic         ovf_trap;
    } decoded_t;

    // outcome seen by the requester
    typedef struct packed {
        word_t        result;
        reg_addr_t    dest;
        result_kind_t kind;
    } exec_out_t;

endpackage

// File: logic/mips_exec_unit.sv
`timescale 1ns/1ps

module mips_exec_unit import mips_exec_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req,
    input  exec_req_t req_data,
    output logic      ack,
    output exec_out_t rsp
);

    // decode to execute
    decoded_t  dec;
    // execute to result
    exec_out_t exe_out;

    // field split, immediates, operand select
    instr_decode instr_decode_i (
        .req_data (req_data),
        .dec      (dec)
    );

    // alu plus trap and r0 handling
    alu_execute alu_execute_i (
        .dec (dec),
        .out (exe_out)
    );

    // capture and req/ack handshake
    result_stage result_stage_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .out    (exe_out),
        .ack    (ack),
        .rsp    (rsp)
    );

endmodule

// File: logic/result_stage.sv
`timescale 1ns/1ps

module result_stage import mips_exec_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  logic      req,
    input  exec_out_t out,
    output logic      ack,
    output exec_out_t rsp
);

    // four-phase handshake states
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_ACKED = 1'b1
    } hs_state_t;

    hs_state_t state;
    hs_state_t state_nxt;
    logic      capture;

    // take the outcome on the rising req phase only
    assign capture = (state == ST_IDLE) && req;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                // req seen, ack goes up at this edge
                if (req) begin
                    state_nxt = ST_ACKED;
                end
            end
            ST_ACKED: begin
                // requester let go, close the handshake
                if (!req) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // response holding register
    // frozen while acked, so req_data changes during the hold are ignored
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // all zero is kind none
            rsp <= '0;
        end else if (capture) begin
            rsp <= out;
        end
    end

    // ack straight from the state flop
    assign ack = (state == ST_ACKED);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with verilator and runs it from the project root
# exit status is nonzero when the build fails or the testbench stops on $fatal

cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module mips_exec_unit_tb -o mips_exec_unit_tb \
    && ./obj_dir/mips_exec_unit_tb \
    || { echo "simulation did not complete cleanly"; exit 1; }

// File: verilog.f
logic/mips_exec_pkg.sv
logic/alu_control_decode.sv
logic/instr_decode.sv
logic/alu_execute.sv
logic/result_stage.sv
logic/mips_exec_unit.sv
bench/mips_exec_unit_tb.sv
